/* all.f */
common/swBufCfgPkg.sv
common/swBufFmtPkg.sv
src/flowPacker.sv
src/flowFifo.sv
src/busReader.sv
swRxBuf/swRxBuf.sv
test/swRxBufTest.sv
test/testbench.sv

/* common/swBufCfgPkg.sv */
// Receive buffer configuration
// sizes and counts shared by the packers, FIFOs and reader
`default_nettype none

package swBufCfgPkg;

  localparam int FLOWS           = 2;   // number of receive flows
  localparam int RX_DATA_WIDTH   = 16;  // flow word width
  localparam int DATA_WIDTH      = 64;  // buffer and bus word width
  localparam int BLOCK_SIZE      = 16;  // FIFO depth in buffer words
  localparam int WORDS_PER_BLOCK = 4;   // input words per buffer word
  localparam int FLOW_ID_WIDTH   = 1;   // flow index width

  // derived sizes
  localparam int LANE_WIDTH   = $clog2(WORDS_PER_BLOCK);  // lane counter bits
  localparam int PTR_WIDTH    = $clog2(BLOCK_SIZE);       // FIFO address bits
  localparam int BYTES_PER_RX = RX_DATA_WIDTH / 8;        // bytes per flow word

endpackage : swBufCfgPkg

`default_nettype wire

/* common/swBufFmtPkg.sv */
// Buffer word formats
// a stored word is either packed payload or a packet descriptor
`default_nettype none

package swBufFmtPkg;

  // descriptor appended after the last data word of a packet
  typedef struct packed {
    logic [7:0]  flowId;     // source flow
    logic [15:0] byteCount;  // packet length in bytes
    logic [15:0] seqNum;     // per-flow packet number, wraps
    logic [23:0] reserved;   // always zero
  } pktDesc_t;

  // one buffer word, decoded by the descriptor tag that travels beside it
  typedef union packed {
    logic [swBufCfgPkg::DATA_WIDTH-1:0] raw;   // payload lanes, lane 0 in the low bits
    pktDesc_t                           desc;  // descriptor view
  } bufWord_u;

endpackage : swBufFmtPkg

`default_nettype wire

/* run.sh */
#!/bin/sh
# Verilator build and run of the receive buffer testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module testbench -Mdir obj_dir -f all.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtestbench > sim.log 2>&1
status=$?
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; }
[ "$status" -eq 0 ] || { echo "FAIL: simulation aborted"; exit 1; }
echo "PASS"

/* src/busReader.sv */
// Bus reader
// round-robin drain of the flow FIFOs, whole packets at a time, onto the wide bus
`timescale 1ns/1ps
`default_nettype none

module busReader (
  input  wire logic                                         CLK,
  input  wire logic                                         rstN,
  input  wire swBufFmtPkg::bufWord_u [swBufCfgPkg::FLOWS-1:0] fifoData,
  input  wire logic [swBufCfgPkg::FLOWS-1:0]                fifoDesc,
  input  wire logic [swBufCfgPkg::FLOWS-1:0]                fifoValid,
  output logic [swBufCfgPkg::FLOWS-1:0]                     fifoReady,
  output swBufFmtPkg::bufWord_u                             outData,
  output logic                                              outDesc,
  output logic                                              outValid,
  output logic [swBufCfgPkg::FLOW_ID_WIDTH-1:0]             outFlow,
  input  wire logic                                         outReady
);

  import swBufCfgPkg::*;
  import swBufFmtPkg::*;

  logic [FLOW_ID_WIDTH-1:0] grant;    // last served flow
  logic                     pktOpen;  // grant locked until descriptor
  logic [FLOW_ID_WIDTH-1:0] nextRr;   // next non-empty flow after grant
  logic [FLOW_ID_WIDTH-1:0] selFlow;  // flow read this cycle
  logic                     loadOk;   // output register free or draining
  logic                     take;

  // round-robin search, starting one past the current grant
  always_comb begin
    int idx;
    nextRr = grant;
    for (int i = FLOWS; i >= 1; i--) begin  // lowest offset wins
      idx = (int'(grant) + i) % FLOWS;
      if (fifoValid[idx]) nextRr = FLOW_ID_WIDTH'(idx);
    end
  end

  assign selFlow = pktOpen ? grant : nextRr;
  assign loadOk  = ~outValid | outReady;
  assign take    = loadOk & fifoValid[selFlow];

  always_comb begin
    fifoReady          = '0;
    fifoReady[selFlow] = take;  // only the granted FIFO is popped
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      grant    <= '0;
      pktOpen  <= 1'b0;
      outValid <= 1'b0;
      outDesc  <= 1'b0;
      outFlow  <= '0;
    end else begin
      if (take) begin
        grant    <= selFlow;
        pktOpen  <= ~fifoDesc[selFlow];  // descriptor releases the grant
        outValid <= 1'b1;
        outDesc  <= fifoDesc[selFlow];
        outFlow  <= selFlow;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (take) outData <= fifoData[selFlow];
  end

  // bus handshake, held while stalled
  assert property (@(posedge CLK) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outData) && $stable(outDesc) &&
    $stable(outFlow))
    else $error("busReader: output changed during stall");

  // descriptor written by the packer agrees with the served flow
  assert property (@(posedge CLK) disable iff (!rstN)
    outValid && outDesc |-> outData.desc.flowId == 8'(outFlow))
    else $error("busReader: descriptor flowId differs from outFlow");

endmodule : busReader

`default_nettype wire

/* src/flowFifo.sv */
// Flow FIFO
// circular buffer of tagged buffer words, valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module flowFifo (
  input  wire logic                  CLK,
  input  wire logic                  rstN,
  input  wire swBufFmtPkg::bufWord_u wrData,
  input  wire logic                  wrDesc,
  input  wire logic                  wrValid,
  output logic                       wrReady,
  output swBufFmtPkg::bufWord_u      rdData,
  output logic                       rdDesc,
  output logic                       rdValid,
  input  wire logic                  rdReady
);

  import swBufCfgPkg::*;
  import swBufFmtPkg::*;

  bufWord_u           memData [BLOCK_SIZE];  // stored words
  logic               memDesc [BLOCK_SIZE];  // descriptor tags
  logic [PTR_WIDTH:0] wrPtr;                 // msb is the wrap bit
  logic [PTR_WIDTH:0] rdPtr;
  logic [PTR_WIDTH:0] fill;                  // current occupancy
  logic               full;
  logic               empty;
  logic               wrFire;
  logic               rdFire;

  assign fill  = wrPtr - rdPtr;
  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[PTR_WIDTH] != rdPtr[PTR_WIDTH]) &&
                 (wrPtr[PTR_WIDTH-1:0] == rdPtr[PTR_WIDTH-1:0]);  // same slot, other lap

  assign wrReady = ~full;
  assign rdValid = ~empty;
  assign wrFire  = wrValid & wrReady;
  assign rdFire  = rdValid & rdReady;

  // head of queue, visible the cycle after it was written
  assign rdData = memData[rdPtr[PTR_WIDTH-1:0]];
  assign rdDesc = memDesc[rdPtr[PTR_WIDTH-1:0]];

  always_ff @(posedge CLK) begin
    if (wrFire) begin
      memData[wrPtr[PTR_WIDTH-1:0]] <= wrData;
      memDesc[wrPtr[PTR_WIDTH-1:0]] <= wrDesc;
    end
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (wrFire) wrPtr <= wrPtr + 1'b1;
      if (rdFire) rdPtr <= rdPtr + 1'b1;  // simultaneous read and write ok
    end
  end

  // occupancy bound
  assert property (@(posedge CLK) disable iff (!rstN) fill <= (PTR_WIDTH+1)'(BLOCK_SIZE))
    else $error("flowFifo: occupancy above depth");

  // reader only pops a FIFO that holds a word
  assert property (@(posedge CLK) disable iff (!rstN) rdReady |-> !empty)
    else $error("flowFifo: read requested while empty");

endmodule : flowFifo

`default_nettype wire

/* src/flowPacker.sv */
// Flow packer
// gathers narrow receive words into buffer words, closes each packet with a descriptor
`timescale 1ns/1ps
`default_nettype none

module flowPacker (
  input  wire logic                                  CLK,
  input  wire logic                                  rstN,
  input  wire logic [swBufCfgPkg::FLOW_ID_WIDTH-1:0] flowId,
  input  wire logic [swBufCfgPkg::RX_DATA_WIDTH-1:0] rxData,
  input  wire logic                                  rxSop,
  input  wire logic                                  rxEop,
  input  wire logic                                  rxValid,
  output logic                                       rxReady,
  output swBufFmtPkg::bufWord_u                      pkData,
  output logic                                       pkDesc,
  output logic                                       pkValid,
  input  wire logic                                  pkReady
);

  import swBufCfgPkg::*;
  import swBufFmtPkg::*;

  logic [LANE_WIDTH-1:0] laneCnt;   // next free lane
  logic [DATA_WIDTH-1:0] asmData;   // partial buffer word
  logic [15:0]           byteCnt;   // bytes of current packet
  logic [15:0]           seqNum;    // packets sent on this flow
  logic                  descPend;  // eop taken, descriptor not yet gone
  logic                  pktOpen;   // between sop and eop
  logic                  live;      // high from first cycle after reset
  logic                  rxFire;
  logic                  pkFire;
  logic                  flush;     // this input word completes a buffer word
  logic [LANE_WIDTH-1:0] lane;      // lane of incoming word
  logic [DATA_WIDTH-1:0] asmNext;   // assembly incl incoming word
  bufWord_u              descWord;  // descriptor for current packet

  // take input only when the output register is free or draining
  assign rxReady = live & ~descPend & (~pkValid | pkReady);
  assign rxFire  = rxValid & rxReady;
  assign pkFire  = pkValid & pkReady;

  always_comb begin
    lane    = rxSop ? '0 : laneCnt;  // sop restarts at lane 0
    asmNext = rxSop ? '0 : asmData;
    asmNext[lane*RX_DATA_WIDTH +: RX_DATA_WIDTH] = rxData;
    flush   = rxFire & (rxEop | (lane == LANE_WIDTH'(WORDS_PER_BLOCK - 1)));
  end

  always_comb begin
    descWord.raw            = '0;  // reserved bits stay zero
    descWord.desc.flowId    = 8'(flowId);
    descWord.desc.byteCount = byteCnt;
    descWord.desc.seqNum    = seqNum;
  end

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      live     <= 1'b0;
      laneCnt  <= '0;
      asmData  <= '0;
      byteCnt  <= '0;
      seqNum   <= '0;
      descPend <= 1'b0;
      pktOpen  <= 1'b0;
      pkValid  <= 1'b0;
      pkDesc   <= 1'b0;
    end else begin
      live <= 1'b1;
      if (pkFire) begin
        if (pkDesc) begin           // descriptor taken, packet closed
          pkValid  <= 1'b0;
          pkDesc   <= 1'b0;
          descPend <= 1'b0;
        end else if (descPend) begin  // last data gone, descriptor next
          pkDesc  <= 1'b1;
          seqNum  <= seqNum + 16'd1;
          byteCnt <= '0;
        end else begin
          pkValid <= 1'b0;
        end
      end
      if (rxFire) begin
        byteCnt <= byteCnt + 16'(BYTES_PER_RX);
        pktOpen <= ~rxEop;
        if (flush) begin
          laneCnt  <= '0;
          asmData  <= '0;             // unused lanes of next word start at zero
          pkValid  <= 1'b1;
          pkDesc   <= 1'b0;
          descPend <= rxEop;
        end else begin
          laneCnt <= lane + 1'b1;
          asmData <= asmNext;
        end
      end
    end
  end

  // output payload, loaded from assembly or with the descriptor
  always_ff @(posedge CLK) begin
    if (flush) begin
      pkData.raw <= asmNext;
    end else if (pkFire && !pkDesc && descPend) begin
      pkData <= descWord;
    end
  end

  // a new packet only starts after the previous one saw eop
  assert property (@(posedge CLK) disable iff (!rstN) rxFire && rxSop |-> !pktOpen)
    else $error("flowPacker: sop accepted inside an open packet");

endmodule : flowPacker

`default_nettype wire

/* swRxBuf/swRxBuf.sv */
// Software receive buffer top
// one packer and one FIFO per flow, a shared round-robin reader on the output bus
`timescale 1ns/1ps
`default_nettype none

module swRxBuf (
  input  wire logic                                                      CLK,
  input  wire logic                                                      rstN,
  input  wire logic [swBufCfgPkg::FLOWS*swBufCfgPkg::RX_DATA_WIDTH-1:0] rxData,
  input  wire logic [swBufCfgPkg::FLOWS-1:0]                             rxSop,
  input  wire logic [swBufCfgPkg::FLOWS-1:0]                             rxEop,
  input  wire logic [swBufCfgPkg::FLOWS-1:0]                             rxValid,
  output logic [swBufCfgPkg::FLOWS-1:0]                                  rxReady,
  output swBufFmtPkg::bufWord_u                                          outData,
  output logic                                                           outDesc,
  output logic [swBufCfgPkg::FLOW_ID_WIDTH-1:0]                          outFlow,
  output logic                                                           outValid,
  input  wire logic                                                      outReady
);

  import swBufCfgPkg::*;
  import swBufFmtPkg::*;

  bufWord_u [FLOWS-1:0] pkData;     // packer to FIFO
  logic     [FLOWS-1:0] pkDesc;
  logic     [FLOWS-1:0] pkValid;
  logic     [FLOWS-1:0] pkReady;
  bufWord_u [FLOWS-1:0] fifoData;   // FIFO to reader
  logic     [FLOWS-1:0] fifoDesc;
  logic     [FLOWS-1:0] fifoValid;
  logic     [FLOWS-1:0] fifoReady;

  for (genvar i = 0; i < FLOWS; i++) begin : gFlow
    flowPacker uPacker (
      .CLK     (CLK),
      .rstN    (rstN),
      .flowId  (FLOW_ID_WIDTH'(i)),  // flow number of this lane
      .rxData  (rxData[i*RX_DATA_WIDTH +: RX_DATA_WIDTH]),
      .rxSop   (rxSop[i]),
      .rxEop   (rxEop[i]),
      .rxValid (rxValid[i]),
      .rxReady (rxReady[i]),
      .pkData  (pkData[i]),
      .pkDesc  (pkDesc[i]),
      .pkValid (pkValid[i]),
      .pkReady (pkReady[i])
    );

    flowFifo uFifo (
      .CLK     (CLK),
      .rstN    (rstN),
      .wrData  (pkData[i]),
      .wrDesc  (pkDesc[i]),
      .wrValid (pkValid[i]),
      .wrReady (pkReady[i]),
      .rdData  (fifoData[i]),
      .rdDesc  (fifoDesc[i]),
      .rdValid (fifoValid[i]),
      .rdReady (fifoReady[i])
    );
  end

  busReader uReader (
    .CLK       (CLK),
    .rstN      (rstN),
    .fifoData  (fifoData),
    .fifoDesc  (fifoDesc),
    .fifoValid (fifoValid),
    .fifoReady (fifoReady),
    .outData   (outData),
    .outDesc   (outDesc),
    .outValid  (outValid),
    .outFlow   (outFlow),
    .outReady  (outReady)
  );

endmodule : swRxBuf

`default_nettype wire

/* test/swRxBufTest.sv */
// Receive buffer test module
// random packets on every flow, per-flow expected queues, bus checks and timeout
`timescale 1ns/1ps
`default_nettype none

module swRxBufTest (
  input  wire logic                                                      CLK,
  input  wire logic                                                      rstN,
  output logic [swBufCfgPkg::FLOWS*swBufCfgPkg::RX_DATA_WIDTH-1:0]       rxData,
  output logic [swBufCfgPkg::FLOWS-1:0]                                  rxSop,
  output logic [swBufCfgPkg::FLOWS-1:0]                                  rxEop,
  output logic [swBufCfgPkg::FLOWS-1:0]                                  rxValid,
  input  wire logic [swBufCfgPkg::FLOWS-1:0]                             rxReady,
  input  wire swBufFmtPkg::bufWord_u                                     outData,
  input  wire logic                                                      outDesc,
  input  wire logic [swBufCfgPkg::FLOW_ID_WIDTH-1:0]                     outFlow,
  input  wire logic                                                      outValid,
  output logic                                                           outReady,
  output logic                                                           testDone,
  output logic                                                           timedOut,
  output int                                                             valueErrs,
  output int                                                             otherErrs,
  output int                                                             wordsChecked
);

  import swBufCfgPkg::*;
  import swBufFmtPkg::*;

  localparam int          NUM_PKTS       = 40;  // packets per flow
  localparam int          MAX_LEN        = 20;  // input words per packet
  localparam int          DRAIN_CYCLES   = 50;  // quiet time once all is received
  localparam int          TIMEOUT_CYCLES = NUM_PKTS * 24 * 4 + 200;
  localparam logic [31:0] SEED           = 32'he9f009a2;
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;  // x^32+x^22+x^2+x+1

  typedef struct packed {
    logic     isDesc;
    bufWord_u word;
  } expEntry_t;

  expEntry_t   expQ [FLOWS][$];              // expected bus words per flow
  logic [31:0] lfsr [FLOWS+1];               // one state per flow, last for the sink
  logic [15:0] sentWords [FLOWS][MAX_LEN];   // packet being sent
  int          pktLen [FLOWS];               // 0 when no packet open
  int          wordIdx [FLOWS];
  int          pktsSent [FLOWS];
  logic [15:0] seqNum [FLOWS];
  logic        noStall;                      // sink always ready in drain phase
  int          cycleCount = 0;
  logic        rstSeen = 1'b0;
  logic        inPkt = 1'b0;                 // bus between data and descriptor
  logic [FLOW_ID_WIDTH-1:0] pktFlow = '0;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);  // galois, shift right
  endfunction

  function automatic int takeBits(input int src, input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr[src][0]);  // one step per bit
      lfsr[src] = lfsrNext(lfsr[src]);
    end
    return val;
  endfunction

  // expected buffer words and descriptor of one sent packet
  function automatic void packPacket(input int f, input int len, input logic [15:0] seq);
    expEntry_t e;
    int        lane;
    e = '0;
    for (int i = 0; i < len; i++) begin
      lane = i % WORDS_PER_BLOCK;  // low lanes first
      e.word.raw[lane*RX_DATA_WIDTH +: RX_DATA_WIDTH] = sentWords[f][i];
      if (lane == WORDS_PER_BLOCK - 1 || i == len - 1) begin
        expQ[f].push_back(e);
        e.word.raw = '0;  // unused lanes stay zero
      end
    end
    e.isDesc              = 1'b1;
    e.word.raw            = '0;
    e.word.desc.flowId    = 8'(f);
    e.word.desc.byteCount = 16'(len * 2);  // two bytes per input word
    e.word.desc.seqNum    = seq;
    expQ[f].push_back(e);
  endfunction

  function automatic logic allSent();
    for (int f = 0; f < FLOWS; f++) begin
      if (pktsSent[f] != NUM_PKTS || pktLen[f] != 0 || rxValid[f]) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic logic queuesEmpty();
    for (int f = 0; f < FLOWS; f++) begin
      if (expQ[f].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic compareFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      valueErrs++;
      $display("Fail %0t %s got %0b expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic compareWord(input string name, input bufWord_u got, input bufWord_u exp);
    if (got.raw !== exp.raw) begin
      valueErrs++;
      $display("Fail %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic compareDesc(input string name, input pktDesc_t got, input pktDesc_t exp);
    if (got !== exp) begin
      valueErrs++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // advance one flow by a cycle, after the edge
  task automatic stepFlow(input int f, input logic accepted);
    if (accepted) begin
      wordIdx[f]++;
      if (wordIdx[f] == pktLen[f]) pktLen[f] = 0;  // eop went out
    end
    if (rxValid[f] && !accepted) return;  // hold during back-pressure
    if (pktLen[f] == 0) begin
      if (pktsSent[f] == NUM_PKTS) begin
        rxValid[f] = 1'b0;
        return;
      end
      // first two packets 4 and 8 words, then random
      pktLen[f]  = (pktsSent[f] < 2) ? 4 * (pktsSent[f] + 1) : takeBits(f, 5) % MAX_LEN + 1;
      wordIdx[f] = 0;
      for (int i = 0; i < pktLen[f]; i++) sentWords[f][i] = 16'(takeBits(f, 16));
      packPacket(f, pktLen[f], seqNum[f]);
      seqNum[f]++;
      pktsSent[f]++;
    end
    if (takeBits(f, 2) == 0) begin
      rxValid[f] = 1'b0;  // idle gap
    end else begin
      rxData[f*RX_DATA_WIDTH +: RX_DATA_WIDTH] = sentWords[f][wordIdx[f]];
      rxSop[f]   = (wordIdx[f] == 0);
      rxEop[f]   = (wordIdx[f] == pktLen[f] - 1);
      rxValid[f] = 1'b1;
    end
  endtask

  task automatic checkOutput();
    expEntry_t exp;
    int        f;
    f = int'(outFlow);
    wordsChecked++;
    if (inPkt && outFlow != pktFlow) begin
      otherErrs++;
      $display("%0t: bus switched from flow %0d to flow %0d inside a packet",
               $time, pktFlow, outFlow);
    end
    inPkt   = !outDesc;
    pktFlow = outFlow;
    if (expQ[f].size() == 0) begin
      otherErrs++;
      $display("%0t: extra word on flow %0d, nothing left to receive", $time, f);
      return;
    end
    exp = expQ[f].pop_front();
    compareFlag("outDesc", outDesc, exp.isDesc);
    if (exp.isDesc) compareDesc("outData.desc", outData.desc, exp.word.desc);
    else compareWord("outData", outData, exp.word);
  endtask

  // stimulus for all flows, then wait for the bus to drain
  initial begin
    logic [FLOWS-1:0] acc;
    rxData   = '0;
    rxSop    = '0;
    rxEop    = '0;
    rxValid  = '0;
    testDone = 1'b0;
    noStall  = 1'b0;
    for (int f = 0; f <= FLOWS; f++) lfsr[f] = SEED ^ 32'(f);
    for (int f = 0; f < FLOWS; f++) begin
      pktLen[f]   = 0;
      wordIdx[f]  = 0;
      pktsSent[f] = 0;
      seqNum[f]   = '0;
    end
    wait (rstN === 1'b1);
    while (!allSent()) begin
      @(negedge CLK);
      acc = rxValid & rxReady;  // transfers at the coming edge
      @(posedge CLK);
      #1;
      for (int f = 0; f < FLOWS; f++) stepFlow(f, acc[f]);
    end
    while (!queuesEmpty()) @(negedge CLK);
    noStall = 1'b1;
    repeat (DRAIN_CYCLES) @(negedge CLK);  // watch for extra words
    testDone = 1'b1;
  end

  // bus sink with random stalls
  initial begin
    outReady = 1'b0;
    wait (rstN === 1'b1);
    forever begin
      @(posedge CLK);
      #1;
      outReady = noStall || (takeBits(FLOWS, 2) != 0);
    end
  end

  // checks at mid-cycle, where every DUT output has settled
  always @(negedge CLK) begin
    cycleCount++;
    if (!rstN || !rstSeen) begin
      compareFlag("outValid", outValid, 1'b0);  // in reset and first cycle after
      for (int f = 0; f < FLOWS; f++) compareFlag($sformatf("rxReady[%0d]", f), rxReady[f], 1'b0);
      rstSeen = rstN;
    end else if (outValid && outReady) begin
      checkOutput();
    end
    if (cycleCount == TIMEOUT_CYCLES) begin
      otherErrs++;
      $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    end
    timedOut = (cycleCount >= TIMEOUT_CYCLES);
  end

endmodule : swRxBufTest

`default_nettype wire

/* test/testbench.sv */
// Receive buffer testbench top
// clock, reset, DUT and test module, final verdict
`timescale 1ns/1ps
`default_nettype none

module testbench;

  import swBufCfgPkg::*;
  import swBufFmtPkg::*;

  logic                            CLK = 1'b0;
  logic                            rstN;
  logic [FLOWS*RX_DATA_WIDTH-1:0]  rxData;
  logic [FLOWS-1:0]                rxSop;
  logic [FLOWS-1:0]                rxEop;
  logic [FLOWS-1:0]                rxValid;
  logic [FLOWS-1:0]                rxReady;
  bufWord_u                        outData;
  logic                            outDesc;
  logic [FLOW_ID_WIDTH-1:0]        outFlow;
  logic                            outValid;
  logic                            outReady;
  logic                            testDone;   // stimulus and drain finished
  logic                            timedOut;
  int                              valueErrs;  // wrong values
  int                              otherErrs;  // protocol, ordering, timeout
  int                              wordsChecked;

  always #5 CLK = ~CLK;  // 10 ns period

  initial begin
    rstN = 1'b0;
    repeat (8) @(posedge CLK);
    #1 rstN = 1'b1;  // released just after an edge
  end

  swRxBuf u_dut (
    .CLK      (CLK),
    .rstN     (rstN),
    .rxData   (rxData),
    .rxSop    (rxSop),
    .rxEop    (rxEop),
    .rxValid  (rxValid),
    .rxReady  (rxReady),
    .outData  (outData),
    .outDesc  (outDesc),
    .outFlow  (outFlow),
    .outValid (outValid),
    .outReady (outReady)
  );

  swRxBufTest uTest (
    .CLK          (CLK),
    .rstN         (rstN),
    .rxData       (rxData),
    .rxSop        (rxSop),
    .rxEop        (rxEop),
    .rxValid      (rxValid),
    .rxReady      (rxReady),
    .outData      (outData),
    .outDesc      (outDesc),
    .outFlow      (outFlow),
    .outValid     (outValid),
    .outReady     (outReady),
    .testDone     (testDone),
    .timedOut     (timedOut),
    .valueErrs    (valueErrs),
    .otherErrs    (otherErrs),
    .wordsChecked (wordsChecked)
  );

  initial begin
    wait (testDone === 1'b1 || timedOut === 1'b1);
    #1;
    $display("summary: %0d value errors, %0d other errors, %0d bus words checked",
             valueErrs, otherErrs, wordsChecked);
    if (valueErrs == 0 && otherErrs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : testbench

`default_nettype wire
